// ==== program.hex ====
// One 32-bit instruction word per line in hex
// Line order is word index, first word at the ROM base
00100093
00200113
00300193
00400213
00500293
00600313
00700393
00800413
00900493
00a00513
00b00593
00c00613
00d00693
00e00713
00f00793
01000093
01100113
01200193
01300213
01400293
01500313
01600393
01700413
01800493
01900513
01a00593
01b00613
01c00693
01d00713
01e00793
01f00093
02000113
02100193
02200213
02300293
02400313
02500393
02600413
02700493
02800513
02900593
02a00613
02b00693
02c00713
02d00793
02e00093
02f00113
03000193
03100213
03200293
03300313
03400393
03500413
03600493
03700513
03800593
03900613
03a00693
03b00713
03c00793
03d00093
03e00113
03f00193
04000213

// ==== sim.f ====
verilog/fetch_pkg.sv
verilog/fetch_unit.sv
verilog/inst_rom_axi.sv
verilog/fetch_skid_buffer.sv
verilog/fetch_top.sv
verif/clock_gen.sv
verif/fetch_assert.sv
verif/fetch_tb.sv

// ==== verif/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
    parameter int RESET_CYCLES = 8
) (
    output logic clock,
    output logic reset
);

    // 10 ns period
    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Reset held for a fixed count of cycles, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end

endmodule

// ==== verif/fetch_assert.sv ====
`timescale 1ns/1ps

module fetch_assert (
    input logic             clock,
    input logic             reset,
    input logic             arvalid,
    input logic             arready,
    input fetch_pkg::addr_t araddr,
    input logic             rvalid,
    input logic             rready,
    input logic             out_valid,
    input logic             out_ready,
    input fetch_pkg::addr_t out_pc,
    input fetch_pkg::inst_t out_inst,
    input logic             out_fault
);

    // Failed assertion count
    int unsigned fail_count = 0;

    // Own view of the single outstanding read
    logic outstanding;

    always_ff @(posedge clock) begin
        if (reset) begin
            outstanding <= 1'b0;
        end else if (arvalid && arready) begin
            outstanding <= 1'b1;
        end else if (rvalid && rready) begin
            outstanding <= 1'b0;
        end
    end

    // ------------------------------
    // AXI read address channel
    // ------------------------------

    ar_hold_a: assert property (@(posedge clock) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else begin
            $error("arvalid or araddr changed before arready");
            fail_count++;
        end

    ar_single_a: assert property (@(posedge clock) disable iff (reset)
        outstanding |-> !arvalid)
        else begin
            $error("arvalid raised while a read is outstanding");
            fail_count++;
        end

    // ------------------------------
    // Decode side
    // ------------------------------

    out_hold_a: assert property (@(posedge clock) disable iff (reset)
        out_valid && !out_ready |=>
            out_valid && $stable(out_pc) && $stable(out_inst) && $stable(out_fault))
        else begin
            $error("output item changed before out_ready");
            fail_count++;
        end

    // Buffer empty once reset has been seen
    out_reset_a: assert property (@(posedge clock)
        reset |=> !out_valid)
        else begin
            $error("out_valid high right after reset");
            fail_count++;
        end

endmodule

bind fetch_top fetch_assert assert_i (
    .clock     (clock),
    .reset     (reset),
    .arvalid   (arvalid),
    .arready   (arready),
    .araddr    (araddr),
    .rvalid    (rvalid),
    .rready    (rready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_pc    (out_pc),
    .out_inst  (out_inst),
    .out_fault (out_fault)
);

// ==== verif/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb;

    localparam fetch_pkg::addr_t RESET_PC     = 32'h2000_0000;
    localparam int               ROM_WORDS    = 64;
    localparam int               READ_LATENCY = 2;

    // Back-pressure modes
    localparam int MODE_NONE   = 0;
    localparam int MODE_RANDOM = 1;

    // Cycle limit for any single wait
    localparam int WAIT_LIMIT = 100;

    typedef struct {
        string            name;
        int               delay;
        logic             redirect;
        fetch_pkg::addr_t target;
        logic             stall;
        int               mode;
    } row_t;

    logic             clock;
    logic             reset;
    logic             redirect;
    fetch_pkg::addr_t redirect_pc;
    logic             stall;
    logic             out_ready;
    logic             out_valid;
    fetch_pkg::addr_t out_pc;
    fetch_pkg::inst_t out_inst;
    logic             out_fault;

    // Model state
    fetch_pkg::inst_t rom_image [ROM_WORDS];
    fetch_pkg::addr_t model_pc;
    row_t             rows [$];
    logic [31:0]      lfsr;
    int               errors;
    int               n_out;
    int               row_errors;
    int               row_outs;
    int unsigned      assert_fails;
    bit               timed_out;

    clock_gen #(
        .RESET_CYCLES (8)
    ) clock_gen_i (
        .clock (clock),
        .reset (reset)
    );

    fetch_top #(
        .RESET_PC     (RESET_PC),
        .ROM_WORDS    (ROM_WORDS),
        .READ_LATENCY (READ_LATENCY)
    ) dut_i (
        .clock       (clock),
        .reset       (reset),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .stall       (stall),
        .out_ready   (out_ready),
        .out_valid   (out_valid),
        .out_pc      (out_pc),
        .out_inst    (out_inst),
        .out_fault   (out_fault)
    );

    // ------------------------------
    // Reference model
    // ------------------------------

    // Galois LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    // Word aligned and inside the ROM window
    function automatic bit rom_hit(input fetch_pkg::addr_t pc);
        if (pc[1:0] != 2'b00 || pc < RESET_PC) begin
            return 1'b0;
        end
        return ((pc - RESET_PC) / 4) < ROM_WORDS;
    endfunction

    function automatic fetch_pkg::inst_t expected_inst(input fetch_pkg::addr_t pc);
        if (!rom_hit(pc)) begin
            return '0;
        end
        return rom_image[int'((pc - RESET_PC) >> 2)];
    endfunction

    // Stall beats redirect, redirect beats the sequential step
    function automatic fetch_pkg::addr_t next_pc(input fetch_pkg::addr_t pc,
                                                 input logic req_redirect,
                                                 input fetch_pkg::addr_t req_target,
                                                 input logic req_stall);
        if (req_stall) begin
            return pc;
        end
        if (req_redirect) begin
            return req_target;
        end
        return pc + 32'd4;
    endfunction

    // ------------------------------
    // Compare tasks
    // ------------------------------

    task automatic check_pc(input fetch_pkg::addr_t got, input fetch_pkg::addr_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: output %0d pc %h, expected %h", $time, n_out, got, exp);
            errors++;
        end
    endtask

    task automatic check_inst(input fetch_pkg::inst_t got, input fetch_pkg::inst_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: output %0d inst %h, expected %h", $time, n_out, got, exp);
            errors++;
        end
    endtask

    task automatic check_fault(input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t: output %0d fault %b, expected %b", $time, n_out, got, exp);
            errors++;
        end
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------

    function automatic void add_row(input string name, input int delay, input logic req_redirect,
                                    input fetch_pkg::addr_t req_target, input logic req_stall,
                                    input int mode);
        row_t row;
        row.name     = name;
        row.delay    = delay;
        row.redirect = req_redirect;
        row.target   = req_target;
        row.stall    = req_stall;
        row.mode     = mode;
        rows.push_back(row);
    endfunction

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        while (reset && !timed_out) begin
            @(negedge clock);
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("timeout: reset never released");
                timed_out = 1'b1;
            end
        end
    endtask

    // Accept one output while holding the request until the next output shows
    task automatic take_output(input int mode, input logic req_redirect,
                               input fetch_pkg::addr_t req_target, input logic req_stall);
        int               waited;
        bit               got_it;
        fetch_pkg::addr_t pc_seen;
        fetch_pkg::inst_t inst_seen;
        logic             fault_seen;
        waited = 0;
        got_it = 1'b0;
        while (!got_it && !timed_out) begin
            @(negedge clock);
            if (waited == 0) begin
                redirect    = req_redirect;
                redirect_pc = req_target;
                stall       = req_stall;
            end else if (out_valid) begin
                redirect = 1'b0;
                stall    = 1'b0;
            end
            if (mode == MODE_RANDOM) begin
                lfsr      = lfsr_step(lfsr);
                out_ready = lfsr[0];
            end else begin
                out_ready = 1'b1;
            end
            if (out_valid && out_ready) begin
                got_it     = 1'b1;
                pc_seen    = out_pc;
                inst_seen  = out_inst;
                fault_seen = out_fault;
            end else if (waited >= WAIT_LIMIT) begin
                $display("timeout: output %0d not accepted within %0d cycles", n_out, WAIT_LIMIT);
                timed_out = 1'b1;
            end
            waited++;
        end
        if (got_it) begin
            // Handshake completes on this edge
            @(posedge clock);
            check_pc(pc_seen, model_pc);
            check_inst(inst_seen, expected_inst(model_pc));
            check_fault(fault_seen, !rom_hit(model_pc));
            model_pc = next_pc(model_pc, req_redirect, req_target, req_stall);
            n_out++;
        end
    endtask

    initial begin
        redirect    = 1'b0;
        redirect_pc = '0;
        stall       = 1'b0;
        out_ready   = 1'b0;
        errors      = 0;
        n_out       = 0;
        timed_out   = 1'b0;
        lfsr        = 32'h9821_e76f;
        model_pc    = RESET_PC;
        $readmemh("program.hex", rom_image);

        // Request rows run without back-pressure
        // Three calm outputs drain the buffer after a random row
        add_row("reset sequence", 6, 1'b0, '0, 1'b0, MODE_NONE);
        add_row("redirect in range", 1, 1'b1, RESET_PC + 32'h80, 1'b0, MODE_NONE);
        add_row("after redirect", 3, 1'b0, '0, 1'b0, MODE_NONE);
        add_row("single stall", 1, 1'b0, '0, 1'b1, MODE_NONE);
        add_row("stall twice", 0, 1'b0, '0, 1'b1, MODE_NONE);
        add_row("redirect past end", 2, 1'b1, RESET_PC + 32'h100, 1'b0, MODE_NONE);
        add_row("redirect misaligned", 2, 1'b1, RESET_PC + 32'h42, 1'b0, MODE_NONE);
        add_row("redirect below base", 2, 1'b1, RESET_PC - 32'h4, 1'b0, MODE_NONE);
        add_row("redirect back", 2, 1'b1, RESET_PC + 32'h10, 1'b0, MODE_NONE);
        add_row("random back-pressure", 20, 1'b0, '0, 1'b0, MODE_RANDOM);
        add_row("redirect near end", 3, 1'b1, RESET_PC + 32'he0, 1'b0, MODE_NONE);
        add_row("run off the end", 12, 1'b0, '0, 1'b0, MODE_RANDOM);
        add_row("stall on faults", 3, 1'b0, '0, 1'b1, MODE_NONE);
        add_row("recover", 3, 1'b1, RESET_PC + 32'h4, 1'b0, MODE_NONE);
        add_row("random tail", 24, 1'b0, '0, 1'b0, MODE_RANDOM);
        add_row("drain", 2, 1'b0, '0, 1'b0, MODE_NONE);

        wait_reset_release();

        for (int r = 0; r < rows.size() && !timed_out; r++) begin
            row_errors = errors;
            row_outs   = n_out;
            for (int i = 0; i < rows[r].delay && !timed_out; i++) begin
                take_output(rows[r].mode, 1'b0, '0, 1'b0);
            end
            if ((rows[r].redirect || rows[r].stall) && !timed_out) begin
                take_output(MODE_NONE, rows[r].redirect, rows[r].target, rows[r].stall);
            end
            if (!timed_out) begin
                $display("row %0d %s: %0d outputs, %0d mismatches", r, rows[r].name,
                         n_out - row_outs, errors - row_errors);
            end
        end

        // Assertions on the last edge settle first
        repeat (2) @(negedge clock);
        assert_fails = dut_i.assert_i.fail_count;
        $display("%0d outputs checked, %0d mismatches, %0d assertion failures, timeout %0d",
                 n_out, errors, assert_fails, timed_out);
        if (errors == 0 && assert_fails == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== verilog/fetch_pkg.sv ====
// Shared types and codes for the instruction fetch path

package fetch_pkg;

    // ------------------------------
    // Widths with a meaning
    // ------------------------------

    // Byte address and program counter
    typedef logic [31:0] addr_t;

    // One 32-bit instruction word
    typedef logic [31:0] inst_t;

    // AXI read response field
    typedef logic [1:0] resp_t;

    // ------------------------------
    // AXI response codes
    // ------------------------------

    // Normal completion
    localparam resp_t RESP_OKAY = 2'b00;

    // Slave error for addresses the ROM does not decode
    localparam resp_t RESP_SLVERR = 2'b10;

endpackage

// ==== verilog/fetch_skid_buffer.sv ====
`timescale 1ns/1ps

module fetch_skid_buffer (
    input  logic             clock,
    input  logic             reset,
    // From fetch
    input  logic             fetch_valid,
    input  fetch_pkg::addr_t fetch_pc,
    input  fetch_pkg::inst_t fetch_inst,
    input  logic             fetch_fault,
    output logic             fetch_ready,
    // To decode
    input  logic             out_ready,
    output logic             out_valid,
    output fetch_pkg::addr_t out_pc,
    output fetch_pkg::inst_t out_inst,
    output logic             out_fault
);

    // Head entry drives the outputs, skid entry holds the overflow
    logic             head_valid;
    fetch_pkg::addr_t head_pc;
    fetch_pkg::inst_t head_inst;
    logic             head_fault;
    logic             skid_valid;
    fetch_pkg::addr_t skid_pc;
    fetch_pkg::inst_t skid_inst;
    logic             skid_fault;
    logic             push;
    logic             pop;
    logic             head_load;

    // Full only when the skid entry is taken
    assign fetch_ready = ~skid_valid;

    assign push      = fetch_valid & fetch_ready;
    assign pop       = head_valid & out_ready;
    assign head_load = ~head_valid | out_ready;

    // ------------------------------
    // Occupancy
    // ------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            head_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            if (head_load) begin
                head_valid <= skid_valid | push;
            end
            if (skid_valid & pop) begin
                // Skid moves up to the head
                skid_valid <= 1'b0;
            end else if (push & head_valid & ~pop) begin
                skid_valid <= 1'b1;
            end
        end
    end

    // ------------------------------
    // Payload
    // ------------------------------

    always_ff @(posedge clock) begin
        if (head_load) begin
            // Older skid entry goes first
            if (skid_valid) begin
                head_pc    <= skid_pc;
                head_inst  <= skid_inst;
                head_fault <= skid_fault;
            end else if (push) begin
                head_pc    <= fetch_pc;
                head_inst  <= fetch_inst;
                head_fault <= fetch_fault;
            end
        end
        // Skid is free whenever a push is possible
        if (push) begin
            skid_pc    <= fetch_pc;
            skid_inst  <= fetch_inst;
            skid_fault <= fetch_fault;
        end
    end

    assign out_valid = head_valid;
    assign out_pc    = head_pc;
    assign out_inst  = head_inst;
    assign out_fault = head_fault;

endmodule

// ==== verilog/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top #(
    parameter fetch_pkg::addr_t RESET_PC     = 32'h2000_0000,
    parameter int               ROM_WORDS    = 64,
    parameter int               READ_LATENCY = 2
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             redirect,
    input  fetch_pkg::addr_t redirect_pc,
    input  logic             stall,
    input  logic             out_ready,
    output logic             out_valid,
    output fetch_pkg::addr_t out_pc,
    output fetch_pkg::inst_t out_inst,
    output logic             out_fault
);

    // AXI read channels
    logic             arvalid;
    logic             arready;
    fetch_pkg::addr_t araddr;
    logic             rvalid;
    logic             rready;
    fetch_pkg::inst_t rdata;
    fetch_pkg::resp_t rresp;

    // Fetch to buffer
    logic             fetch_valid;
    logic             fetch_ready;
    fetch_pkg::addr_t fetch_pc;
    fetch_pkg::inst_t fetch_inst;
    logic             fetch_fault;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) fetch_unit_i (
        .clock       (clock),
        .reset       (reset),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .stall       (stall),
        .arready     (arready),
        .arvalid     (arvalid),
        .araddr      (araddr),
        .rvalid      (rvalid),
        .rdata       (rdata),
        .rresp       (rresp),
        .rready      (rready),
        .fetch_ready (fetch_ready),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_inst  (fetch_inst),
        .fetch_fault (fetch_fault)
    );

    // ROM base is the reset PC
    inst_rom_axi #(
        .RESET_PC     (RESET_PC),
        .ROM_WORDS    (ROM_WORDS),
        .READ_LATENCY (READ_LATENCY)
    ) inst_rom_axi_i (
        .clock   (clock),
        .reset   (reset),
        .arvalid (arvalid),
        .araddr  (araddr),
        .arready (arready),
        .rready  (rready),
        .rvalid  (rvalid),
        .rdata   (rdata),
        .rresp   (rresp)
    );

    fetch_skid_buffer fetch_skid_buffer_i (
        .clock       (clock),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_inst  (fetch_inst),
        .fetch_fault (fetch_fault),
        .fetch_ready (fetch_ready),
        .out_ready   (out_ready),
        .out_valid   (out_valid),
        .out_pc      (out_pc),
        .out_inst    (out_inst),
        .out_fault   (out_fault)
    );

endmodule

// ==== verilog/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit #(
    parameter fetch_pkg::addr_t RESET_PC = 32'h2000_0000
) (
    input  logic             clock,
    input  logic             reset,
    // Requests from later stages
    input  logic             redirect,
    input  fetch_pkg::addr_t redirect_pc,
    input  logic             stall,
    // AXI read address channel
    input  logic             arready,
    output logic             arvalid,
    output fetch_pkg::addr_t araddr,
    // AXI read data channel
    input  logic             rvalid,
    input  fetch_pkg::inst_t rdata,
    input  fetch_pkg::resp_t rresp,
    output logic             rready,
    // Towards the skid buffer
    input  logic             fetch_ready,
    output logic             fetch_valid,
    output fetch_pkg::addr_t fetch_pc,
    output fetch_pkg::inst_t fetch_inst,
    output logic             fetch_fault
);

    fetch_pkg::addr_t pc;
    fetch_pkg::addr_t target_q;
    logic             redirect_q;
    logic             stall_q;
    logic             arvalid_q;
    logic             outstanding;
    logic             ar_fire;
    logic             beat;
    logic             capture;

    // ------------------------------
    // Handshake events
    // ------------------------------

    assign ar_fire = arvalid_q & arready;
    // R beat and buffer push are one event
    assign beat    = rvalid & fetch_ready;

    // Sample requests only while idle and nothing held
    assign capture = ~beat & ~redirect_q & ~stall_q;

    // ------------------------------
    // Request latch
    // ------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            redirect_q <= 1'b0;
            stall_q    <= 1'b0;
        end else if (capture) begin
            redirect_q <= redirect;
            stall_q    <= stall;
        end else if (beat) begin
            // Consumed by this beat
            redirect_q <= 1'b0;
            stall_q    <= 1'b0;
        end
    end

    // Target follows the same sampling window
    always_ff @(posedge clock) begin
        if (capture) begin
            target_q <= redirect_pc;
        end
    end

    // ------------------------------
    // Program counter
    // ------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (beat) begin
            if (stall | stall_q) begin
                pc <= pc;
            end else if (redirect_q) begin
                pc <= target_q;
            end else if (redirect) begin
                pc <= redirect_pc;
            end else begin
                pc <= pc + 32'd4;
            end
        end
    end

    // ------------------------------
    // Read request tracking
    // ------------------------------

    // arvalid and outstanding are never high together
    always_ff @(posedge clock) begin
        if (reset) begin
            arvalid_q   <= 1'b0;
            outstanding <= 1'b0;
        end else begin
            if (ar_fire) begin
                arvalid_q   <= 1'b0;
                outstanding <= 1'b1;
            end else if (~outstanding | beat) begin
                // First request after reset, or next one after a beat
                arvalid_q   <= 1'b1;
                outstanding <= 1'b0;
            end
        end
    end

    // PC only moves on a beat, so the address is stable while valid
    assign arvalid = arvalid_q;
    assign araddr  = pc;

    // Data straight through to the buffer
    assign rready      = fetch_ready;
    assign fetch_valid = rvalid;
    assign fetch_pc    = pc;
    assign fetch_inst  = rdata;
    assign fetch_fault = (rresp == fetch_pkg::RESP_SLVERR);

endmodule

// ==== verilog/inst_rom_axi.sv ====
`timescale 1ns/1ps

module inst_rom_axi #(
    parameter fetch_pkg::addr_t RESET_PC     = 32'h2000_0000,
    parameter int               ROM_WORDS    = 64,
    parameter int               READ_LATENCY = 2
) (
    input  logic             clock,
    input  logic             reset,
    // Read address channel
    input  logic             arvalid,
    input  fetch_pkg::addr_t araddr,
    output logic             arready,
    // Read data channel
    input  logic             rready,
    output logic             rvalid,
    output fetch_pkg::inst_t rdata,
    output fetch_pkg::resp_t rresp
);

    localparam int IDX_W = $clog2(ROM_WORDS);
    localparam int CNT_W = $clog2(READ_LATENCY + 1);

    fetch_pkg::inst_t mem [ROM_WORDS];

    fetch_pkg::addr_t offset;
    logic             in_range;
    logic [IDX_W-1:0] idx_q;
    logic             err_q;
    logic [CNT_W-1:0] cnt;
    logic             busy;
    logic             rvalid_q;
    fetch_pkg::inst_t rdata_q;
    fetch_pkg::resp_t rresp_q;
    logic             ar_fire;
    logic             r_fire;

    // ROM image
    initial begin
        $readmemh("program.hex", mem);
    end

    // ------------------------------
    // Address decode
    // ------------------------------

    // Below the base wraps to a large offset and falls out of range
    assign offset   = araddr - RESET_PC;
    assign in_range = (offset < fetch_pkg::addr_t'(ROM_WORDS * 4)) && (araddr[1:0] == 2'b00);

    assign ar_fire = arvalid & arready;
    assign r_fire  = rvalid_q & rready;

    // Accept a new address only when idle
    assign arready = ~busy;

    always_ff @(posedge clock) begin
        if (ar_fire) begin
            idx_q <= offset[IDX_W+1:2];
            err_q <= ~in_range;
        end
    end

    // ------------------------------
    // Latency counter
    // ------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            busy     <= 1'b0;
            rvalid_q <= 1'b0;
            cnt      <= '0;
        end else if (ar_fire) begin
            busy <= 1'b1;
            cnt  <= CNT_W'(READ_LATENCY);
        end else if (r_fire) begin
            busy     <= 1'b0;
            rvalid_q <= 1'b0;
        end else if (busy & ~rvalid_q) begin
            // Last count raises rvalid
            if (cnt == CNT_W'(1)) begin
                rvalid_q <= 1'b1;
            end
            cnt <= cnt - CNT_W'(1);
        end
    end

    // Beat payload read as the counter expires and held until rready
    always_ff @(posedge clock) begin
        if (busy & ~rvalid_q & (cnt == CNT_W'(1))) begin
            if (err_q) begin
                rdata_q <= '0;
                rresp_q <= fetch_pkg::RESP_SLVERR;
            end else begin
                rdata_q <= mem[idx_q];
                rresp_q <= fetch_pkg::RESP_OKAY;
            end
        end
    end

    assign rvalid = rvalid_q;
    assign rdata  = rdata_q;
    assign rresp  = rresp_q;

endmodule
